// File: files.f
+incdir+logic
logic/ntt_pkg.sv
logic/ntt_butterfly.sv
logic/ntt_engine.sv
logic/coef_fifo.sv
logic/result_drain.sv
logic/ntt_top.sv
tb/ntt_tb.sv

// File: logic/coef_fifo.sv
// synchronous coefficient FIFO between the NTT engine and the result drain, registered read data
`timescale 1ns/100ps
`include "ntt_defs.svh"

module coef_fifo
    import ntt_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  coef_t wr_data,
    input  logic  pop,
    output coef_t rd_data,
    output logic  full,
    output logic  empty
);

    localparam int PTR_W = $clog2(`COEF_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`COEF_FIFO_DEPTH + 1);

    coef_t            mem [`COEF_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full  = (count == CNT_W'(`COEF_FIFO_DEPTH));
    assign empty = (count == '0);

    // pointers wrap on the power-of-two depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + PTR_W'(1);
            if (pop) rd_ptr <= rd_ptr + PTR_W'(1);
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // data shows on rd_data the cycle after the pop
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= wr_data;
        if (pop) rd_data <= mem[rd_ptr];
    end

    // --------------------
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) !(push && full)
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) !(pop && empty)
    );

endmodule

// File: logic/ntt_butterfly.sv
// one combinational Montgomery butterfly lane, replicated per lane inside the NTT engine
`timescale 1ns/100ps
`include "ntt_defs.svh"

module ntt_butterfly
    import ntt_pkg::*;
(
    input  bfly_in_t  in,
    output bfly_out_t out
);

    localparam int          PROD_W = `COEF_W + `TW_W;
    localparam int          R_W    = 16;
    localparam coef_t       Q      = coef_t'(`NTT_Q);
    localparam logic [15:0] QINV   = 16'(`NTT_QINV);

    logic [PROD_W-1:0] prod;
    logic [R_W-1:0]    u;
    logic [31:0]       t;
    coef_t             z;
    coef_t             m;
    logic [`COEF_W:0]  s;

    // Montgomery reduction of b*w, result below 2q
    assign prod = PROD_W'(in.b) * PROD_W'(in.w);
    assign u    = R_W'(prod[R_W-1:0] * QINV);
    assign t    = 32'(prod) + 32'(u) * 32'(Q);
    assign z    = t[R_W +: `COEF_W];
    // single subtract lands it in [0, q)
    assign m    = (z >= Q) ? z - Q : z;

    // modular sum and difference
    assign s        = {1'b0, in.a} + {1'b0, m};
    assign out.sum  = (s >= {1'b0, Q}) ? coef_t'(s - {1'b0, Q}) : s[`COEF_W-1:0];
    assign out.diff = (in.a >= m) ? in.a - m : in.a + Q - m;

    always_comb begin
        if (!$isunknown(in) && !$isunknown(out)) begin
            assert (out.sum < Q && out.diff < Q)
                else $error("butterfly result not reduced: sum %0d diff %0d", out.sum, out.diff);
        end
    end

endmodule

// File: logic/ntt_defs.svh
// sizes, modulus and depth constants for the NTT datapath, included by the package and RTL
`ifndef NTT_DEFS_SVH
`define NTT_DEFS_SVH

// --------------------
// transform geometry
`define NTT_N           128
`define NTT_LANES       8
`define NTT_WORDS       16
`define NTT_STAGES      7
`define NTT_STEPS       56

// modulus and Montgomery constant, -q^-1 mod 2^16
`define NTT_Q           12289
`define NTT_QINV        12287

// --------------------
// widths and buffering
`define COEF_W          16
`define TW_W            14
`define NIB_W           4
`define WORD_W          32
`define COEF_FIFO_DEPTH 16

`endif

// File: logic/ntt_engine.sv
// NTT engine: collects a block of input words, runs the staged butterfly schedule, pushes results
`timescale 1ns/100ps
`include "ntt_defs.svh"

module ntt_engine
    import ntt_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [`WORD_W-1:0] in_data,
    input  logic               fifo_full,
    output logic               fifo_push,
    output coef_t              fifo_wdata,
    output logic               busy
);

    localparam int CPW       = `WORD_W / `NIB_W;
    localparam int PER_STAGE = `NTT_STEPS / `NTT_STAGES;
    localparam int IDX_W     = $clog2(`NTT_N);
    localparam int STEP_W    = $clog2(`NTT_STEPS + 1);
    localparam int WCNT_W    = $clog2(`NTT_WORDS);
    localparam logic [STEP_W-1:0] STEP_END = STEP_W'(`NTT_STEPS);

    typedef enum logic [1:0] {S_IDLE, S_COLLECT, S_XFORM, S_EMIT} state_t;

    state_t            state_q;
    state_t            state_d;
    logic [WCNT_W-1:0] word_cnt;
    logic [STEP_W-1:0] step_cnt;
    logic [IDX_W-1:0]  emit_cnt;
    logic              accept;
    logic              issue;
    coef_t             store [`NTT_N];

    // butterfly pipeline, operand stage then result stage
    logic              op_valid;
    logic [STEP_W-1:0] op_step;
    bfly_in_t          op_q [`NTT_LANES];
    bfly_out_t         res_d [`NTT_LANES];
    logic              res_valid;
    logic [STEP_W-1:0] res_step;
    bfly_out_t         res_q [`NTT_LANES];

    // --------------------
    // schedule arithmetic

    function automatic logic [2:0] stage_of(input logic [STEP_W-1:0] step);
        return 3'(step / PER_STAGE);
    endfunction

    // 64 >> stage
    function automatic logic [IDX_W-1:0] half_len(input logic [STEP_W-1:0] step);
        return IDX_W'(`NTT_N / 2) >> stage_of(step);
    endfunction

    // butterfly number inside the stage
    function automatic logic [IDX_W-2:0] bfly_num(
        input logic [STEP_W-1:0] step,
        input int                lane
    );
        return (IDX_W-1)'((step % PER_STAGE) * `NTT_LANES + lane);
    endfunction

    function automatic logic [IDX_W-2:0] group_of(
        input logic [STEP_W-1:0] step,
        input int                lane
    );
        return bfly_num(step, lane) >> (3'(IDX_W - 1) - stage_of(step));
    endfunction

    // index of operand a; its partner sits half_len above
    function automatic logic [IDX_W-1:0] top_index(
        input logic [STEP_W-1:0] step,
        input int                lane
    );
        logic [IDX_W-1:0] p;
        p = IDX_W'(bfly_num(step, lane));
        return (IDX_W'(group_of(step, lane)) << (3'(IDX_W) - stage_of(step)))
             | (p & (half_len(step) - IDX_W'(1)));
    endfunction

    function automatic logic [IDX_W-1:0] tw_index(
        input logic [STEP_W-1:0] step,
        input int                lane
    );
        return (IDX_W'(1) << stage_of(step)) + IDX_W'(group_of(step, lane));
    endfunction

    // --------------------
    // control

    assign busy       = (state_q == S_XFORM) || (state_q == S_EMIT);
    assign accept     = in_valid && !busy;
    assign issue      = (state_q == S_XFORM) && (step_cnt != STEP_END);
    assign fifo_push  = (state_q == S_EMIT) && !fifo_full;
    assign fifo_wdata = store[emit_cnt];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) state_d = S_COLLECT;
            end
            S_COLLECT: begin
                if (accept && word_cnt == WCNT_W'(`NTT_WORDS - 1)) state_d = S_XFORM;
            end
            // leave once the final write-back is in its last cycle
            S_XFORM: begin
                if (step_cnt == STEP_END && !op_valid) state_d = S_EMIT;
            end
            S_EMIT: begin
                if (fifo_push && emit_cnt == IDX_W'(`NTT_N - 1)) state_d = S_IDLE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= S_IDLE;
            word_cnt  <= '0;
            step_cnt  <= '0;
            emit_cnt  <= '0;
            op_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            op_valid  <= issue;
            res_valid <= op_valid;
            if (accept) word_cnt <= word_cnt + WCNT_W'(1);
            if (issue) begin
                step_cnt <= step_cnt + STEP_W'(1);
            end else if (state_q != S_XFORM) begin
                step_cnt <= '0;
            end
            if (fifo_push) emit_cnt <= emit_cnt + IDX_W'(1);
        end
    end

    // --------------------
    // datapath

    always_ff @(posedge clk) begin
        if (issue) begin
            op_step <= step_cnt;
            for (int l = 0; l < `NTT_LANES; l++) begin
                op_q[l].a <= store[top_index(step_cnt, l)];
                op_q[l].b <= store[top_index(step_cnt, l) + half_len(step_cnt)];
                op_q[l].w <= TWIDDLE_TABLE[tw_index(step_cnt, l)];
            end
        end
        if (op_valid) begin
            res_step <= op_step;
            res_q    <= res_d;
        end
    end

    for (genvar g = 0; g < `NTT_LANES; g++) begin : g_lane
        ntt_butterfly u_bfly (
            .in  (op_q[g]),
            .out (res_d[g])
        );
    end

    // new word enters at the top, so word 0 ends up at index 0
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < `NTT_N - CPW; i++) begin
                store[i] <= store[i + CPW];
            end
            for (int j = 0; j < CPW; j++) begin
                store[`NTT_N - CPW + j] <= coef_t'(in_data[j*`NIB_W +: `NIB_W]);
            end
        end else if (res_valid) begin
            for (int l = 0; l < `NTT_LANES; l++) begin
                store[top_index(res_step, l)]                      <= res_q[l].sum;
                store[top_index(res_step, l) + half_len(res_step)] <= res_q[l].diff;
            end
        end
    end

    // --------------------
    a_step_range: assert property (
        @(posedge clk) disable iff (!rst_n) step_cnt <= STEP_END
    );

    // downstream backpressure honoured
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) !(fifo_push && fifo_full)
    );

endmodule

// File: logic/ntt_pkg.sv
// shared NTT types and the Montgomery-form twiddle table, imported by the RTL and testbench
`include "ntt_defs.svh"

package ntt_pkg;

    typedef logic [`COEF_W-1:0] coef_t;
    typedef logic [`TW_W-1:0]   twiddle_t;

    // one butterfly lane, operands in
    typedef struct packed {
        coef_t    a;
        coef_t    b;
        twiddle_t w;
    } bfly_in_t;

    // one butterfly lane, results out
    typedef struct packed {
        coef_t sum;
        coef_t diff;
    } bfly_out_t;

    // --------------------
    // twiddles in Montgomery form, indexed by 2^stage + group
    // entry 0 never addressed
    localparam twiddle_t TWIDDLE_TABLE [`NTT_N] = '{
        14'd0,     14'd7888,  14'd11060, 14'd11208, 14'd6960,  14'd4342,  14'd6275,  14'd9759,
        14'd1591,  14'd6399,  14'd9477,  14'd5266,  14'd586,   14'd5825,  14'd7538,  14'd9710,
        14'd1134,  14'd6407,  14'd1711,  14'd965,   14'd7099,  14'd7674,  14'd3743,  14'd6442,
        14'd10414, 14'd8100,  14'd1885,  14'd1688,  14'd1364,  14'd10329, 14'd10164, 14'd9180,
        14'd12210, 14'd6240,  14'd997,   14'd117,   14'd4783,  14'd4407,  14'd1549,  14'd7072,
        14'd2829,  14'd6458,  14'd4431,  14'd8877,  14'd7144,  14'd2564,  14'd5664,  14'd4042,
        14'd12189, 14'd432,   14'd10751, 14'd1237,  14'd7610,  14'd1534,  14'd3983,  14'd7863,
        14'd2181,  14'd6308,  14'd8720,  14'd6570,  14'd4843,  14'd1690,  14'd14,    14'd3872,
        14'd5569,  14'd9368,  14'd12163, 14'd2019,  14'd7543,  14'd2315,  14'd4673,  14'd7340,
        14'd1553,  14'd1156,  14'd8401,  14'd11389, 14'd1020,  14'd2967,  14'd10772, 14'd7045,
        14'd3316,  14'd11236, 14'd5285,  14'd11578, 14'd10637, 14'd10086, 14'd9493,  14'd6180,
        14'd9277,  14'd6130,  14'd3323,  14'd883,   14'd10469, 14'd489,   14'd1502,  14'd2851,
        14'd11061, 14'd9729,  14'd2742,  14'd12241, 14'd4970,  14'd10481, 14'd10078, 14'd1195,
        14'd730,   14'd1762,  14'd3854,  14'd2030,  14'd5892,  14'd10922, 14'd9020,  14'd5274,
        14'd9179,  14'd3604,  14'd3782,  14'd10206, 14'd3180,  14'd3467,  14'd4668,  14'd2446,
        14'd7613,  14'd9386,  14'd834,   14'd7703,  14'd6836,  14'd3403,  14'd5351,  14'd12276
    };

endpackage

// File: logic/ntt_top.sv
// NTT top level: engine feeding the coefficient FIFO, drained to the output port
`timescale 1ns/100ps
`include "ntt_defs.svh"

module ntt_top
    import ntt_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [`WORD_W-1:0] in_data,
    output logic               busy,
    output logic               out_valid,
    output coef_t              out_data
);

    // engine to fifo
    logic  fifo_push;
    logic  fifo_full;
    coef_t fifo_wdata;

    // fifo to drain
    logic  fifo_pop;
    logic  fifo_empty;
    coef_t fifo_rd_data;

    ntt_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .fifo_full  (fifo_full),
        .fifo_push  (fifo_push),
        .fifo_wdata (fifo_wdata),
        .busy       (busy)
    );

    coef_fifo u_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (fifo_push),
        .wr_data (fifo_wdata),
        .pop     (fifo_pop),
        .rd_data (fifo_rd_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    result_drain u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .fifo_empty   (fifo_empty),
        .fifo_rd_data (fifo_rd_data),
        .fifo_pop     (fifo_pop),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

endmodule

// File: logic/result_drain.sv
// result drain: empties the coefficient FIFO and presents one registered coefficient per cycle
`timescale 1ns/100ps

module result_drain
    import ntt_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  fifo_empty,
    input  coef_t fifo_rd_data,
    output logic  fifo_pop,
    output logic  out_valid,
    output coef_t out_data
);

    // pop strobe delayed to line up with fifo read data
    logic pop_d1;

    assign fifo_pop = !fifo_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_d1    <= 1'b0;
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            pop_d1    <= fifo_pop;
            out_valid <= pop_d1;
            // zero between beats
            out_data  <= pop_d1 ? fifo_rd_data : '0;
        end
    end

    a_valid_after_pop: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> $past(fifo_pop, 2)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the NTT testbench with Verilator, then judge the run from its log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f files.f --top-module ntt_tb -o ntt_sim

status=0
./obj_dir/ntt_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation finished cleanly"

// File: tb/ntt_tb.sv
// self-checking testbench for ntt_top, directed and random blocks against a reference NTT model
`timescale 1ns/100ps
`include "ntt_defs.svh"

module ntt_tb
    import ntt_pkg::*;
();

    localparam int Q       = `NTT_Q;
    localparam int MAX_GAP = 3;
    // six blocks of about 220 cycles plus worst-case gaps, reset and margin
    localparam int TIMEOUT_CYCLES = 10 + 6 * 220 + `NTT_WORDS * MAX_GAP + 600;

    typedef logic [`WORD_W-1:0] word_arr_t [`NTT_WORDS];
    typedef coef_t              coef_arr_t [`NTT_N];

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic [`WORD_W-1:0] in_data;
    logic               busy;
    logic               out_valid;
    coef_t              out_data;

    logic [31:0] lcg_state;
    coef_t       expected_q [$];
    coef_t       exp_coef;
    int          cycle_cnt = 0;
    int          out_idx = 0;
    int          word_seen = 0;
    int          push_cnt = 0;
    logic        busy_due = 1'b0;
    logic        busy_prev = 1'b0;

    ntt_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // reference model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int mod_pow(input int base, input int exp);
        int r;
        int b;
        int e;
        r = 1;
        b = base % Q;
        e = exp;
        while (e > 0) begin
            if (e % 2 == 1) r = (r * b) % Q;
            b = (b * b) % Q;
            e = e / 2;
        end
        return r;
    endfunction

    // nibble unpack then 7 Cooley-Tukey stages with m = b*w*2^-16 mod q
    function automatic void ref_ntt(input word_arr_t words, output coef_arr_t result);
        int v [`NTT_N];
        int rinv;
        int len;
        int grp;
        int x;
        int m;
        int a;
        rinv = mod_pow(65536 % Q, Q - 2);
        for (int k = 0; k < `NTT_WORDS; k++) begin
            for (int i = 0; i < 8; i++) begin
                v[8 * k + i] = int'((words[k] >> (4 * i)) & 32'hf);
            end
        end
        for (int s = 0; s < `NTT_STAGES; s++) begin
            len = 64 >> s;
            for (int p = 0; p < 64; p++) begin
                grp        = p / len;
                x          = grp * 2 * len + p % len;
                m          = (v[x + len] * int'(TWIDDLE_TABLE[(1 << s) + grp])) % Q;
                m          = (m * rinv) % Q;
                a          = v[x];
                v[x]       = (a + m) % Q;
                v[x + len] = (a - m + Q) % Q;
            end
        end
        for (int i = 0; i < `NTT_N; i++) begin
            result[i] = coef_t'(v[i]);
        end
    endfunction

    // --------------------
    // reporting and stimulus

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic send_block(input word_arr_t words, input bit with_gaps);
        int gap;
        for (int k = 0; k < `NTT_WORDS; k++) begin
            gap = with_gaps ? int'(lcg_next() % 32'(MAX_GAP + 1)) : 0;
            repeat (gap) begin
                @(posedge clk);
                #10;
                in_valid = 1'b0;
            end
            @(posedge clk);
            #10;
            in_valid = 1'b1;
            in_data  = words[k];
        end
        @(posedge clk);
        #10;
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    // send and queue the expected result then return once busy drops
    task automatic run_block(input word_arr_t words, input bit with_gaps);
        coef_arr_t expected;
        send_block(words, with_gaps);
        ref_ntt(words, expected);
        foreach (expected[i]) expected_q.push_back(expected[i]);
        while (busy) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #10;
        end
        repeat (4) @(posedge clk);
        #10;
    endtask

    // --------------------
    // monitors

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // busy rises after the 16th word and falls only after 128 pushes
    always @(negedge clk) begin
        if (rst_n) begin
            if (busy_due) check_value("busy", 32'd1, 32'(busy));
            busy_due = 1'b0;
            if (busy_prev && !busy) begin
                check_value("u_dut.fifo_push count", 32'd128, 32'(push_cnt));
                push_cnt = 0;
            end
            if (busy && u_dut.fifo_push) push_cnt++;
            if (in_valid && !busy) begin
                word_seen++;
                if (word_seen == `NTT_WORDS) begin
                    busy_due  = 1'b1;
                    word_seen = 0;
                end
            end
            busy_prev = busy;
        end
    end

    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (expected_q.size() == 0) begin
                fail_run("out_valid was high with no coefficient outstanding");
            end else begin
                exp_coef = expected_q.pop_front();
                check_value($sformatf("out_data[%0d]", out_idx), 32'(exp_coef), 32'(out_data));
                out_idx = (out_idx + 1) % `NTT_N;
            end
        end else if (rst_n) begin
            check_value("out_data", 32'd0, 32'(out_data));
        end
    end

    // --------------------
    initial begin : main_seq
        word_arr_t words;
        word_arr_t first_words;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        lcg_state = 32'h1122_f9bb;
        repeat (10) @(posedge clk);
        #10;
        rst_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_value("busy", 32'd0, 32'(busy));
            check_value("out_valid", 32'd0, 32'(out_valid));
        end

        foreach (words[k]) words[k] = '0;
        run_block(words, 1'b0);
        wait_drained();

        // unit impulse at coefficient 0
        words[0] = 32'h0000_0001;
        run_block(words, 1'b0);
        wait_drained();

        // three random blocks back to back as soon as busy drops
        for (int b = 0; b < 3; b++) begin
            foreach (words[k]) words[k] = lcg_next();
            if (b == 0) first_words = words;
            run_block(words, 1'b0);
        end
        wait_drained();

        // first random block again with idle gaps
        run_block(first_words, 1'b1);
        wait_drained();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
